//--- sort_params.svh
`ifndef SORT_PARAMS_SVH
`define SORT_PARAMS_SVH

// Width of one unsigned key
`define SORT_KEY_WIDTH 16

// Keys held by one chunk sorter lane
`define SORT_CHUNK_SIZE 8

// Longest batch the sorter accepts
`define SORT_MAX_LENGTH 32

`define SORT_LANES (`SORT_MAX_LENGTH / `SORT_CHUNK_SIZE)

`endif

//--- sort_data_pkg.sv
`include "sort_params.svh"

package sort_data_pkg;

    typedef logic [`SORT_KEY_WIDTH-1:0] key_t;

    // Position of a key inside one chunk
    typedef logic [$clog2(`SORT_CHUNK_SIZE)-1:0] slot_t;

    // Element count, one bit wider so that a full batch fits
    typedef logic [$clog2(`SORT_MAX_LENGTH):0] size_t;

    typedef logic [$clog2(`SORT_LANES)-1:0] lane_t;

    // Number of chunks in a batch, from 1 to the lane count
    typedef logic [$clog2(`SORT_LANES):0] count_t;

endpackage

//--- sort_ctrl_pkg.sv
package sort_ctrl_pkg;

    typedef enum logic [1:0] {
        lane_loading,
        lane_sorting,
        lane_sorted
    } lane_state_t;

    typedef enum logic [2:0] {
        fsm_idle,
        fsm_bypass,
        fsm_merging,
        fsm_update_sizes,
        fsm_done
    } merge_state_t;

endpackage

//--- chunk_lane_if.sv
`timescale 1ns/1ps

interface chunk_lane_if ();
    import sort_data_pkg::*;

    // Write side, driven by the distributor
    logic  wr_en;
    slot_t wr_slot;
    key_t  wr_key;
    logic  sort_start;
    logic  sorted;

    // Read side, the merge core picks a slot and gets the key back in the same cycle
    slot_t rd_slot;
    key_t  rd_key;

    modport feeder (output wr_en, wr_slot, wr_key, sort_start, input sorted);
    modport lane (input wr_en, wr_slot, wr_key, sort_start, rd_slot, output sorted, rd_key);
    modport reader (output rd_slot, input rd_key);

endinterface

//--- chunk_distributor.sv
`timescale 1ns/1ps
`include "sort_params.svh"

module chunk_distributor (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  sort_data_pkg::key_t   in_data,
    input  logic                  in_last,
    input  logic                  batch_done,
    output logic                  busy,
    output sort_data_pkg::count_t chunk_count,
    output sort_data_pkg::slot_t  last_chunk_size,
    output logic                  batch_ready,
    chunk_lane_if.feeder          lanes [`SORT_LANES]
);
    import sort_data_pkg::*;

    size_t wp;
    size_t key_count;
    lane_t wr_lane;
    logic  closed;
    logic  padding;
    logic  start_pulse;
    logic  waiting;
    logic  accept;
    logic  wr_any;
    logic [`SORT_LANES-1:0] lane_done;

    // Keys of the open batch are taken until in_last closes it
    assign accept  = in_valid && !closed;
    assign wr_any  = accept || padding;
    assign wr_lane = lane_t'(wp >> $clog2(`SORT_CHUNK_SIZE));

    assign chunk_count = count_t'((key_count + size_t'(`SORT_CHUNK_SIZE - 1))
                                  >> $clog2(`SORT_CHUNK_SIZE));
    // Zero here means the last chunk is full
    assign last_chunk_size = slot_t'(key_count);

    for (genvar g = 0; g < `SORT_LANES; g++) begin : g_lane
        assign lanes[g].wr_en      = wr_any && (wr_lane == lane_t'(g));
        assign lanes[g].wr_slot    = slot_t'(wp);
        assign lanes[g].wr_key     = padding ? '1 : in_data;
        assign lanes[g].sort_start = start_pulse && (count_t'(g) < chunk_count);
        // Lanes beyond the batch never start, so they count as finished
        assign lane_done[g] = lanes[g].sorted || (count_t'(g) >= chunk_count);
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            busy        <= 1'b0;
            closed      <= 1'b0;
            padding     <= 1'b0;
            start_pulse <= 1'b0;
            waiting     <= 1'b0;
            batch_ready <= 1'b0;
            wp          <= '0;
            key_count   <= '0;
        end else begin
            start_pulse <= 1'b0;
            batch_ready <= 1'b0;
            if (batch_done) begin
                busy   <= 1'b0;
                closed <= 1'b0;
                wp     <= '0;
            end
            if (accept) begin
                busy <= 1'b1;
                wp   <= wp + 1'b1;
                if (in_last) begin
                    closed    <= 1'b1;
                    key_count <= wp + 1'b1;
                    // A batch ending on a chunk boundary needs no padding
                    if (slot_t'(wp + 1'b1) == '0) begin
                        start_pulse <= 1'b1;
                    end else begin
                        padding <= 1'b1;
                    end
                end
            end
            if (padding) begin
                wp <= wp + 1'b1;
                if (slot_t'(wp) == slot_t'(`SORT_CHUNK_SIZE - 1)) begin
                    padding     <= 1'b0;
                    start_pulse <= 1'b1;
                end
            end
            if (start_pulse) begin
                waiting <= 1'b1;
            end else if (waiting && (&lane_done)) begin
                waiting     <= 1'b0;
                batch_ready <= 1'b1;
            end
        end
    end

    // The source keeps off the input from in_last until the batch has left the sorter
    a_no_input_when_closed: assert property (@(posedge clock) disable iff (!rst_n)
        closed |-> !in_valid);

endmodule

//--- chunk_sorter.sv
`timescale 1ns/1ps
`include "sort_params.svh"

module chunk_sorter (
    input  logic       clock,
    input  logic       rst_n,
    chunk_lane_if.lane port
);
    import sort_data_pkg::*;
    import sort_ctrl_pkg::*;

    lane_state_t state;
    slot_t       phase;
    key_t        key_r  [`SORT_CHUNK_SIZE];
    key_t        key_nx [`SORT_CHUNK_SIZE];

    // One odd-even transposition phase: even phases compare pairs (0,1),(2,3)..
    // and odd phases compare (1,2),(3,4)..
    always_comb begin
        key_nx = key_r;
        if (state == lane_sorting) begin
            for (int i = 0; i < `SORT_CHUNK_SIZE - 1; i++) begin
                if ((i[0] == phase[0]) && (key_r[i] > key_r[i + 1])) begin
                    key_nx[i]     = key_r[i + 1];
                    key_nx[i + 1] = key_r[i];
                end
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= lane_loading;
            phase <= '0;
        end else begin
            if (port.wr_en) begin
                // A new write means a new batch, so sorted drops
                state <= lane_loading;
            end else if (port.sort_start) begin
                state <= lane_sorting;
                phase <= '0;
            end else if (state == lane_sorting) begin
                phase <= phase + 1'b1;
                if (phase == slot_t'(`SORT_CHUNK_SIZE - 1)) begin
                    state <= lane_sorted;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (port.wr_en) begin
            key_r[port.wr_slot] <= port.wr_key;
        end else begin
            key_r <= key_nx;
        end
    end

    assign port.sorted = (state == lane_sorted);
    assign port.rd_key = key_r[port.rd_slot];

    // The distributor only writes while the lane is idle or already sorted
    a_no_write_while_sorting: assert property (@(posedge clock) disable iff (!rst_n)
        (state == lane_sorting) |-> !port.wr_en);

endmodule

//--- merger_control_unit.sv
`timescale 1ns/1ps
`include "sort_params.svh"

module merger_control_unit (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  batch_ready,
    input  sort_data_pkg::count_t chunk_count,
    input  sort_data_pkg::slot_t  last_chunk_size,
    input  logic                  merge_done,
    output logic                  select_merge_bypass,
    output logic                  core_start,
    output logic                  output_selector,
    output sort_data_pkg::lane_t  chunk_select,
    output sort_data_pkg::size_t  input_chunk_size,
    output sort_data_pkg::size_t  result_size,
    output logic                  batch_done
);
    import sort_data_pkg::*;
    import sort_ctrl_pkg::*;

    localparam size_t CHUNK_LEN = size_t'(`SORT_CHUNK_SIZE);

    merge_state_t state;
    slot_t        byp_cnt;
    size_t        tail_len;
    lane_t        last_lane;
    lane_t        next_lane;

    // Length of the final chunk, which is the only one that may be short
    assign tail_len  = (last_chunk_size == '0) ? CHUNK_LEN : size_t'(last_chunk_size);
    assign last_lane = lane_t'(chunk_count - 1'b1);
    assign next_lane = chunk_select + 1'b1;

    assign batch_done = (state == fsm_done);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state               <= fsm_idle;
            byp_cnt             <= '0;
            select_merge_bypass <= 1'b0;
            core_start          <= 1'b0;
            output_selector     <= 1'b0;
            chunk_select        <= '0;
            input_chunk_size    <= '0;
            result_size         <= '0;
        end else begin
            core_start <= 1'b0;
            case (state)
                fsm_idle: begin
                    if (batch_ready) begin
                        select_merge_bypass <= 1'b1;
                        byp_cnt             <= '0;
                        chunk_select        <= '0;
                        state               <= fsm_bypass;
                        if (chunk_count == count_t'(1)) begin
                            // Lone chunk goes from the bypass straight to the output
                            result_size      <= tail_len;
                            input_chunk_size <= tail_len;
                            output_selector  <= 1'b1;
                        end else begin
                            result_size      <= CHUNK_LEN;
                            input_chunk_size <= (last_lane == lane_t'(1)) ? tail_len : CHUNK_LEN;
                        end
                    end
                end
                fsm_bypass: begin
                    byp_cnt <= byp_cnt + 1'b1;
                    if (byp_cnt == slot_t'(`SORT_CHUNK_SIZE - 1)) begin
                        select_merge_bypass <= 1'b0;
                        if (chunk_count == count_t'(1)) begin
                            state <= fsm_done;
                        end else begin
                            chunk_select    <= lane_t'(1);
                            core_start      <= 1'b1;
                            output_selector <= (last_lane == lane_t'(1));
                            state           <= fsm_merging;
                        end
                    end
                end
                fsm_merging: begin
                    if (merge_done) begin
                        state <= fsm_update_sizes;
                    end
                end
                fsm_update_sizes: begin
                    result_size <= result_size + input_chunk_size;
                    if (chunk_select == last_lane) begin
                        state <= fsm_done;
                    end else begin
                        chunk_select     <= next_lane;
                        input_chunk_size <= (next_lane == last_lane) ? tail_len : CHUNK_LEN;
                        output_selector  <= (next_lane == last_lane);
                        core_start       <= 1'b1;
                        state            <= fsm_merging;
                    end
                end
                fsm_done: begin
                    output_selector <= 1'b0;
                    state           <= fsm_idle;
                end
                default: state <= fsm_idle;
            endcase
        end
    end

    // The core reports a finished merge only while one is outstanding
    a_merge_done_when_merging: assert property (@(posedge clock) disable iff (!rst_n)
        merge_done |-> (state == fsm_merging));

    // A new batch is handed over only once the previous one has left
    a_batch_ready_when_idle: assert property (@(posedge clock) disable iff (!rst_n)
        batch_ready |-> (state == fsm_idle));

endmodule

//--- merge_core.sv
`timescale 1ns/1ps
`include "sort_params.svh"

module merge_core (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 select_merge_bypass,
    input  logic                 core_start,
    input  logic                 output_selector,
    input  sort_data_pkg::lane_t chunk_select,
    input  sort_data_pkg::size_t input_chunk_size,
    input  sort_data_pkg::size_t result_size,
    chunk_lane_if.reader         lanes [`SORT_LANES],
    output logic                 merge_done,
    output logic                 out_valid,
    output sort_data_pkg::key_t  out_data,
    output logic                 out_last
);
    import sort_data_pkg::*;

    localparam int IDX_W = $clog2(`SORT_MAX_LENGTH);

    key_t  res_buf  [`SORT_MAX_LENGTH];
    key_t  shd_buf  [`SORT_MAX_LENGTH];
    key_t  lane_key [`SORT_LANES];
    key_t  buf_key;
    key_t  chunk_key;
    key_t  pick_key;
    slot_t rd_slot;
    slot_t byp_slot;
    size_t i_ptr;
    size_t j_ptr;
    size_t k_ptr;
    size_t total;
    logic  merging;
    logic  take_buf;
    logic [IDX_W-1:0] byp_idx;

    for (genvar g = 0; g < `SORT_LANES; g++) begin : g_lane
        assign lanes[g].rd_slot = rd_slot;
        assign lane_key[g]      = lanes[g].rd_key;
    end

    assign rd_slot   = select_merge_bypass ? byp_slot : slot_t'(j_ptr);
    assign byp_idx   = IDX_W'(byp_slot);
    assign chunk_key = lane_key[chunk_select];
    assign buf_key   = res_buf[i_ptr[IDX_W-1:0]];
    assign total     = result_size + input_chunk_size;

    // Buffer key wins ties, and each side is skipped once it runs out
    assign take_buf = (i_ptr < result_size)
                   && ((j_ptr >= input_chunk_size) || (buf_key <= chunk_key));
    assign pick_key = take_buf ? buf_key : chunk_key;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            merging    <= 1'b0;
            byp_slot   <= '0;
            i_ptr      <= '0;
            j_ptr      <= '0;
            k_ptr      <= '0;
            merge_done <= 1'b0;
            out_valid  <= 1'b0;
            out_last   <= 1'b0;
        end else begin
            merge_done <= 1'b0;
            out_valid  <= 1'b0;
            out_last   <= 1'b0;
            if (select_merge_bypass) begin
                byp_slot <= byp_slot + 1'b1;
                // Padding slots past result_size are copied but never streamed
                if (output_selector && (size_t'(byp_slot) < result_size)) begin
                    out_valid <= 1'b1;
                    out_last  <= (size_t'(byp_slot) == result_size - 1'b1);
                end
            end else begin
                byp_slot <= '0;
            end
            if (core_start) begin
                merging <= 1'b1;
                i_ptr   <= '0;
                j_ptr   <= '0;
                k_ptr   <= '0;
            end else if (merging) begin
                if (take_buf) begin
                    i_ptr <= i_ptr + 1'b1;
                end else begin
                    j_ptr <= j_ptr + 1'b1;
                end
                k_ptr <= k_ptr + 1'b1;
                if (output_selector) begin
                    out_valid <= 1'b1;
                    out_last  <= (k_ptr == total - 1'b1);
                end
                if (k_ptr == total - 1'b1) begin
                    merging    <= 1'b0;
                    merge_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (select_merge_bypass) begin
            res_buf[byp_idx] <= chunk_key;
            out_data         <= chunk_key;
        end else if (merging) begin
            if (!output_selector) begin
                shd_buf[k_ptr[IDX_W-1:0]] <= pick_key;
            end
            out_data <= pick_key;
        end
        // The shadow holds the full merge by now and becomes the new result
        if (merge_done) begin
            res_buf <= shd_buf;
        end
    end

endmodule

//--- merge_sorter_top.sv
`timescale 1ns/1ps
`include "sort_params.svh"

module merge_sorter_top (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                in_valid,
    input  sort_data_pkg::key_t in_data,
    input  logic                in_last,
    output logic                busy,
    output logic                out_valid,
    output sort_data_pkg::key_t out_data,
    output logic                out_last
);
    import sort_data_pkg::*;

    count_t chunk_count;
    slot_t  last_chunk_size;
    lane_t  chunk_select;
    size_t  input_chunk_size;
    size_t  result_size;
    logic   batch_ready;
    logic   batch_done;
    logic   select_merge_bypass;
    logic   core_start;
    logic   output_selector;
    logic   merge_done;

    chunk_lane_if lane_bus [`SORT_LANES] ();

    chunk_distributor u_distributor (
        .clock           (clock),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .in_data         (in_data),
        .in_last         (in_last),
        .batch_done      (batch_done),
        .busy            (busy),
        .chunk_count     (chunk_count),
        .last_chunk_size (last_chunk_size),
        .batch_ready     (batch_ready),
        .lanes           (lane_bus)
    );

    for (genvar g = 0; g < `SORT_LANES; g++) begin : g_sorter
        chunk_sorter u_sorter (
            .clock (clock),
            .rst_n (rst_n),
            .port  (lane_bus[g])
        );
    end

    merger_control_unit u_control (
        .clock               (clock),
        .rst_n               (rst_n),
        .batch_ready         (batch_ready),
        .chunk_count         (chunk_count),
        .last_chunk_size     (last_chunk_size),
        .merge_done          (merge_done),
        .select_merge_bypass (select_merge_bypass),
        .core_start          (core_start),
        .output_selector     (output_selector),
        .chunk_select        (chunk_select),
        .input_chunk_size    (input_chunk_size),
        .result_size         (result_size),
        .batch_done          (batch_done)
    );

    merge_core u_core (
        .clock               (clock),
        .rst_n               (rst_n),
        .select_merge_bypass (select_merge_bypass),
        .core_start          (core_start),
        .output_selector     (output_selector),
        .chunk_select        (chunk_select),
        .input_chunk_size    (input_chunk_size),
        .result_size         (result_size),
        .lanes               (lane_bus),
        .merge_done          (merge_done),
        .out_valid           (out_valid),
        .out_data            (out_data),
        .out_last            (out_last)
    );

endmodule

//--- merge_sorter_tb.sv
`timescale 1ns/1ps
`include "sort_params.svh"

module merge_sorter_tb;
    import sort_data_pkg::*;

    typedef key_t key_q_t [$];

    localparam int CLOCK_PERIOD = 8;
    localparam int NUM_RANDOM   = 40;
    localparam int NUM_BATCHES  = 3 + NUM_RANDOM;

    logic  clock = 1'b0;
    logic  rst_n;
    logic  in_valid;
    key_t  in_data;
    logic  in_last;
    logic  busy;
    logic  out_valid;
    key_t  out_data;
    logic  out_last;

    logic [15:0] lfsr_state;
    key_q_t      exp_keys;
    int          exp_lens [$];
    key_q_t      got_keys;
    int          batches_sent    = 0;
    int          batches_checked = 0;
    int          value_errors    = 0;
    int          protocol_errors = 0;

    merge_sorter_top uut (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_last   (in_last),
        .busy      (busy),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_last  (out_last)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step for every bit handed out
    function automatic logic [31:0] random_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // Plain insertion sort, ascending
    function automatic key_q_t sort_reference(key_q_t keys);
        key_q_t res;
        key_t   tmp;
        int     j;
        res = keys;
        for (int i = 1; i < res.size(); i++) begin
            tmp = res[i];
            j = i - 1;
            while (j >= 0 && res[j] > tmp) begin
                res[j + 1] = res[j];
                j--;
            end
            res[j + 1] = tmp;
        end
        return res;
    endfunction

    task automatic send_batch(input key_q_t keys);
        key_q_t sorted_keys;
        sorted_keys = sort_reference(keys);
        foreach (sorted_keys[k]) begin
            exp_keys.push_back(sorted_keys[k]);
        end
        exp_lens.push_back(keys.size());
        batches_sent++;
        for (int i = 0; i < keys.size(); i++) begin
            @(negedge clock);
            if (i > 0) begin
                assert (busy) else begin
                    protocol_errors++;
                    $display("Busy was low while batch %0d was being sent", batches_sent - 1);
                end
            end
            in_valid = 1'b1;
            in_data  = keys[i];
            in_last  = (i == keys.size() - 1);
        end
        @(negedge clock);
        assert (busy) else begin
            protocol_errors++;
            $display("Busy was low after the last key of batch %0d", batches_sent - 1);
        end
        in_valid = 1'b0;
        in_last  = 1'b0;
        in_data  = '0;
    endtask

    // The next batch may only start once every result is back and busy has dropped
    task automatic wait_batch_done();
        @(negedge clock);
        while (busy || batches_checked < batches_sent) begin
            @(negedge clock);
        end
    endtask

    function automatic void check_batch();
        int   len;
        key_t expect_key;
        len = exp_lens.pop_front();
        assert (got_keys.size() == len) else begin
            protocol_errors++;
            $display("Batch %0d returned %0d keys where %0d were sent",
                     batches_checked, got_keys.size(), len);
        end
        for (int i = 0; i < len; i++) begin
            expect_key = exp_keys.pop_front();
            if (i < got_keys.size()) begin
                assert (got_keys[i] == expect_key) else begin
                    value_errors++;
                    $display("** Error at %0t: batch %0d index %0d expected %h got %h",
                             $time, batches_checked, i, expect_key, got_keys[i]);
                end
            end
        end
        got_keys.delete();
        batches_checked++;
    endfunction

    // Outputs are registered on the rising edge, so they are read on the falling one
    always @(negedge clock) begin
        if (rst_n && out_valid) begin
            assert (busy) else begin
                protocol_errors++;
                $display("Output key at %0t came while busy was low", $time);
            end
            got_keys.push_back(out_data);
            if (exp_lens.size() == 0) begin
                protocol_errors++;
                $display("Output key at %0t arrived with no batch outstanding", $time);
                got_keys.delete();
            end else if (out_last) begin
                check_batch();
            end else if (got_keys.size() >= exp_lens[0]) begin
                protocol_errors++;
                $display("Batch %0d has no out_last on its final key", batches_checked);
                check_batch();
            end
        end
    end

    initial begin
        #(NUM_BATCHES * 400 * CLOCK_PERIOD);
        $display("Watchdog expired after %0d of %0d batches were checked",
                 batches_checked, NUM_BATCHES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        key_q_t keys;
        int     len;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_data    = '0;
        in_last    = 1'b0;
        lfsr_state = 16'd26591;
        repeat (8) @(negedge clock);
        rst_n = 1'b1;

        // Idle sorter must stay quiet
        repeat (16) begin
            @(negedge clock);
            assert (!busy && !out_valid && !out_last) else begin
                protocol_errors++;
                $display("Outputs were active at %0t before any input", $time);
            end
        end

        for (int i = 0; i < `SORT_MAX_LENGTH; i++) begin
            keys.push_back(key_t'(16'hF000 - i * 16'h0101));
        end
        send_batch(keys);
        wait_batch_done();

        keys = '{16'd300, 16'd7, 16'd4095, 16'd7, 16'd12};
        send_batch(keys);
        wait_batch_done();

        // Many duplicates, some equal to the padding key
        keys.delete();
        for (int i = 0; i < 19; i++) begin
            keys.push_back((i % 4 == 0) ? 16'hFFFF : key_t'((i % 3) * 100));
        end
        send_batch(keys);
        wait_batch_done();

        for (int b = 0; b < NUM_RANDOM; b++) begin
            keys.delete();
            len = int'(random_bits(5)) + 1;
            for (int i = 0; i < len; i++) begin
                keys.push_back(key_t'(random_bits(16)));
            end
            send_batch(keys);
            wait_batch_done();
        end

        $display("Checked %0d batches, %0d value errors, %0d protocol errors",
                 batches_checked, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+.
sort_data_pkg.sv
sort_ctrl_pkg.sv
chunk_lane_if.sv
chunk_distributor.sv
chunk_sorter.sv
merger_control_unit.sv
merge_core.sv
merge_sorter_top.sv
merge_sorter_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := merge_sorter_tb
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
